// ==== dv/exu_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module exu_tb;

    localparam int NUM_UOPS      = 600;
    localparam int RESET_CYCLES  = 8;
    localparam int STIM_TIMEOUT  = 20000;
    localparam int DRAIN_TIMEOUT = 2000;
    localparam int IDLE_CYCLES   = 20;

    logic               clk;
    logic               rst_n;
    logic               uop_valid;
    logic               uop_ready;
    exu_pkg::alu_ctrl_t uop_ctrl;
    exu_pkg::reg_idx_t  uop_rd;
    exu_pkg::reg_idx_t  uop_rs0;
    exu_pkg::reg_idx_t  uop_rs1;
    exu_pkg::word_t     uop_imm;
    logic               uop_use_imm;
    logic               wb_valid;
    logic               wb_ready;
    exu_pkg::reg_idx_t  wb_rd;
    exu_pkg::word_t     wb_result;

    // in-order model state
    exu_pkg::word_t     model_regs [exu_pkg::NUM_REGS];
    exu_pkg::reg_idx_t  exp_rd_q [$];
    exu_pkg::word_t     exp_res_q [$];
    logic [15:0]        ops_seen;
    logic               in_fire;
    logic               timed_out;
    int                 n_accepted;
    int                 n_checked;
    int                 n_errors;
    int                 ready_low_left;

    exu_top i_exu_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .uop_valid   (uop_valid),
        .uop_ready   (uop_ready),
        .uop_ctrl    (uop_ctrl),
        .uop_rd      (uop_rd),
        .uop_rs0     (uop_rs0),
        .uop_rs1     (uop_rs1),
        .uop_imm     (uop_imm),
        .uop_use_imm (uop_use_imm),
        .wb_valid    (wb_valid),
        .wb_ready    (wb_ready),
        .wb_rd       (wb_rd),
        .wb_result   (wb_result)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ########################################################################
    // reference model
    // ########################################################################

    function automatic exu_pkg::word_t alu_ref(input exu_pkg::alu_ctrl_t ctrl,
                                               input exu_pkg::word_t     a,
                                               input exu_pkg::word_t     b);
        exu_pkg::word_t res;
        case (ctrl)
            exu_pkg::ALU_ADD:  res = a + b;
            exu_pkg::ALU_SUB:  res = a - b;
            exu_pkg::ALU_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exu_pkg::ALU_SLTU: res = (a < b) ? 32'd1 : 32'd0;
            exu_pkg::ALU_AND:  res = a & b;
            exu_pkg::ALU_OR:   res = a | b;
            exu_pkg::ALU_NOR:  res = ~(a | b);
            exu_pkg::ALU_XOR:  res = a ^ b;
            exu_pkg::ALU_SLL:  res = a << b[4:0];
            exu_pkg::ALU_SRL:  res = a >> b[4:0];
            exu_pkg::ALU_SRA:  res = $signed(a) >>> b[4:0];
            default:           res = '0;
        endcase
        return res;
    endfunction

    // few registers, so RAW and WAW chains are common
    function automatic exu_pkg::reg_idx_t pick_reg();
        exu_pkg::reg_idx_t idx;
        case ($urandom_range(5, 0))
            0:       idx = 5'd0;
            1:       idx = 5'd1;
            2:       idx = 5'd2;
            3:       idx = 5'd3;
            4:       idx = 5'd7;
            default: idx = 5'd31;
        endcase
        return idx;
    endfunction

    always @(negedge clk) begin : input_model
        exu_pkg::word_t op_b;
        exu_pkg::word_t res;
        in_fire = rst_n && uop_valid && uop_ready;
        if (in_fire) begin
            op_b = uop_use_imm ? uop_imm : model_regs[uop_rs1];
            res  = alu_ref(uop_ctrl, model_regs[uop_rs0], op_b);
            if (uop_rd != '0) begin
                model_regs[uop_rd] = res;
            end
            exp_rd_q.push_back(uop_rd);
            exp_res_q.push_back(res);
            ops_seen[uop_ctrl] = 1'b1;
            n_accepted++;
        end
    end

    always @(negedge clk) begin : compare_outputs
        exu_pkg::reg_idx_t exp_rd;
        exu_pkg::word_t    exp_res;
        if (rst_n && wb_valid && wb_ready) begin
            if (exp_rd_q.size() == 0) begin
                $display("%0t ns: output for rd %0d with no micro-op left to match it",
                         $time, wb_rd);
                n_errors++;
            end else begin
                exp_rd  = exp_rd_q.pop_front();
                exp_res = exp_res_q.pop_front();
                n_checked++;
                if (wb_rd !== exp_rd) begin
                    $display("[ERROR] %0t ns wb_rd: got %0d, expected %0d",
                             $time, wb_rd, exp_rd);
                    n_errors++;
                end
                if (wb_result !== exp_res) begin
                    $display("[ERROR] %0t ns wb_result: got %h, expected %h",
                             $time, wb_result, exp_res);
                    n_errors++;
                end
            end
        end
    end

    // ########################################################################
    // helpers
    // ########################################################################

    task automatic finish_run();
        $display("outputs checked: %0d, errors: %0d", n_checked, n_errors);
        if (n_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("%0t ns: timeout, %s", $time, what);
        n_errors++;
        timed_out = 1'b1;
    endtask

    task automatic check_idle(input string when_txt);
        if (wb_valid !== 1'b0) begin
            $display("[ERROR] %0t ns wb_valid %s: got %b, expected 0",
                     $time, when_txt, wb_valid);
            n_errors++;
        end
        if (uop_ready !== 1'b1) begin
            $display("[ERROR] %0t ns uop_ready %s: got %b, expected 1",
                     $time, when_txt, uop_ready);
            n_errors++;
        end
    endtask

    // mostly high, with random low stretches
    task automatic step_ready();
        if (ready_low_left > 0) begin
            ready_low_left--;
            wb_ready <= 1'b0;
        end else if ($urandom_range(9, 0) == 0) begin
            ready_low_left = $urandom_range(12, 1);
            wb_ready <= 1'b0;
        end else begin
            wb_ready <= ($urandom_range(3, 0) != 0);
        end
    endtask

    task automatic drive_new_uop();
        exu_pkg::alu_ctrl_t ctrl;
        if ($urandom_range(7, 0) == 0) begin
            ctrl = exu_pkg::alu_ctrl_t'($urandom_range(15, 11));
        end else begin
            ctrl = exu_pkg::alu_ctrl_t'($urandom_range(10, 0));
        end
        uop_valid   <= 1'b1;
        uop_ctrl    <= ctrl;
        uop_rd      <= pick_reg();
        uop_rs0     <= pick_reg();
        uop_rs1     <= pick_reg();
        uop_imm     <= $urandom();
        uop_use_imm <= ($urandom_range(2, 0) == 0);
    endtask

    task automatic send_uops();
        int offered;
        int guard;
        offered = 0;
        guard   = 0;
        while ((n_accepted < NUM_UOPS) && !timed_out) begin
            @(posedge clk);
            step_ready();
            guard++;
            if (guard > STIM_TIMEOUT) begin
                report_timeout("not all micro-ops were accepted");
            end else if (!uop_valid || in_fire) begin
                // payload held until taken
                if ((offered < NUM_UOPS) && ($urandom_range(3, 0) != 0)) begin
                    drive_new_uop();
                    offered++;
                end else begin
                    uop_valid <= 1'b0;
                end
            end
        end
        @(posedge clk);
        step_ready();
        uop_valid <= 1'b0;
    endtask

    // ########################################################################
    // main sequence
    // ########################################################################

    initial begin : main
        int seed_init;
        int guard;
        seed_init      = $urandom(18849);
        rst_n          = 1'b0;
        uop_valid      = 1'b0;
        uop_ctrl       = '0;
        uop_rd         = '0;
        uop_rs0        = '0;
        uop_rs1        = '0;
        uop_imm        = '0;
        uop_use_imm    = 1'b0;
        wb_ready       = 1'b0;
        in_fire        = 1'b0;
        timed_out      = 1'b0;
        ops_seen       = '0;
        n_accepted     = 0;
        n_checked      = 0;
        n_errors       = 0;
        ready_low_left = 0;
        for (int i = 0; i < exu_pkg::NUM_REGS; i++) begin
            model_regs[i] = '0;
        end

        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check_idle("in reset");
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_idle("after reset");

        send_uops();

        guard = 0;
        while ((exp_rd_q.size() != 0) && !timed_out) begin
            @(posedge clk);
            step_ready();
            guard++;
            if (guard > DRAIN_TIMEOUT) begin
                report_timeout("results still missing after the last micro-op");
            end
        end
        // quiet tail, any extra output shows up here
        repeat (IDLE_CYCLES) begin
            @(posedge clk);
            step_ready();
        end

        // defined and undefined codes alike
        for (int op = 0; op < 16; op++) begin
            if (!ops_seen[op]) begin
                $display("operation code %0d was never exercised", op);
                n_errors++;
            end
        end
        finish_run();
    end

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  wire logic               alu_en_in,
    input  wire exu_pkg::alu_ctrl_t alu_control,
    input  wire exu_pkg::reg_idx_t  alu_rd_in,
    input  wire exu_pkg::word_t     alu_sr0,
    input  wire exu_pkg::word_t     alu_sr1,
    output logic                    alu_en_out,
    output exu_pkg::reg_idx_t       alu_rd_out,
    output exu_pkg::word_t          alu_result
);

    logic op_add;
    logic op_sub;
    logic op_slt;
    logic op_sltu;
    logic op_and;
    logic op_or;
    logic op_nor;
    logic op_xor;
    logic op_sll;
    logic op_srl;
    logic op_sra;
    logic                        use_sub;
    exu_pkg::word_t              adder_b;
    exu_pkg::word_t              adder_sum;
    logic                        adder_cout;
    logic                        slt_bit;
    logic                        sltu_bit;
    logic [exu_pkg::SHAMT_W-1:0] shamt;
    exu_pkg::word_t              mux_out;

    assign op_add  = (alu_control == exu_pkg::ALU_ADD);
    assign op_sub  = (alu_control == exu_pkg::ALU_SUB);
    assign op_slt  = (alu_control == exu_pkg::ALU_SLT);
    assign op_sltu = (alu_control == exu_pkg::ALU_SLTU);
    assign op_and  = (alu_control == exu_pkg::ALU_AND);
    assign op_or   = (alu_control == exu_pkg::ALU_OR);
    assign op_nor  = (alu_control == exu_pkg::ALU_NOR);
    assign op_xor  = (alu_control == exu_pkg::ALU_XOR);
    assign op_sll  = (alu_control == exu_pkg::ALU_SLL);
    assign op_srl  = (alu_control == exu_pkg::ALU_SRL);
    assign op_sra  = (alu_control == exu_pkg::ALU_SRA);

    // shared adder, sr0 + ~sr1 + 1 for sub and compares
    assign use_sub = op_sub | op_slt | op_sltu;
    assign adder_b = use_sub ? ~alu_sr1 : alu_sr1;
    assign {adder_cout, adder_sum} = {1'b0, alu_sr0} + {1'b0, adder_b}
                                   + {{exu_pkg::XLEN{1'b0}}, use_sub};

    // negative vs positive, or same signs and negative difference
    assign slt_bit  = (alu_sr0[exu_pkg::XLEN-1] & ~alu_sr1[exu_pkg::XLEN-1])
                    | (~(alu_sr0[exu_pkg::XLEN-1] ^ alu_sr1[exu_pkg::XLEN-1])
                       & adder_sum[exu_pkg::XLEN-1]);
    // borrow out
    assign sltu_bit = ~adder_cout;
    assign shamt    = alu_sr1[exu_pkg::SHAMT_W-1:0];

    // one-hot select, undefined codes fall through to zero
    assign mux_out = ({exu_pkg::XLEN{op_add | op_sub}} & adder_sum)
                   | ({exu_pkg::XLEN{op_slt}}  & {{(exu_pkg::XLEN-1){1'b0}}, slt_bit})
                   | ({exu_pkg::XLEN{op_sltu}} & {{(exu_pkg::XLEN-1){1'b0}}, sltu_bit})
                   | ({exu_pkg::XLEN{op_and}}  & (alu_sr0 & alu_sr1))
                   | ({exu_pkg::XLEN{op_or}}   & (alu_sr0 | alu_sr1))
                   | ({exu_pkg::XLEN{op_nor}}  & ~(alu_sr0 | alu_sr1))
                   | ({exu_pkg::XLEN{op_xor}}  & (alu_sr0 ^ alu_sr1))
                   | ({exu_pkg::XLEN{op_sll}}  & (alu_sr0 << shamt))
                   | ({exu_pkg::XLEN{op_srl}}  & (alu_sr0 >> shamt))
                   | ({exu_pkg::XLEN{op_sra}}  & exu_pkg::word_t'($signed(alu_sr0) >>> shamt));

    assign alu_en_out = alu_en_in;
    assign alu_rd_out = alu_en_in ? alu_rd_in : '0;
    assign alu_result = alu_en_in ? mux_out : '0;

endmodule

`default_nettype wire

// ==== hdl/exec_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_stage (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               in_valid,
    output logic                    in_ready,
    input  wire exu_pkg::alu_ctrl_t in_ctrl,
    input  wire exu_pkg::reg_idx_t  in_rd,
    input  wire exu_pkg::word_t     in_sr0,
    input  wire exu_pkg::word_t     in_sr1,
    output logic                    out_valid,
    input  wire logic               out_ready,
    output exu_pkg::reg_idx_t       out_rd,
    output exu_pkg::word_t          out_result
);

    logic              alu_en;
    exu_pkg::reg_idx_t alu_rd;
    exu_pkg::word_t    alu_res;

    alu i_alu (
        .alu_en_in   (in_valid),
        .alu_control (in_ctrl),
        .alu_rd_in   (in_rd),
        .alu_sr0     (in_sr0),
        .alu_sr1     (in_sr1),
        .alu_en_out  (alu_en),
        .alu_rd_out  (alu_rd),
        .alu_result  (alu_res)
    );

    // empty, or current result leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= alu_en;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_rd     <= alu_rd;
            out_result <= alu_res;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

    // ########################################################################
    // widths
    // ########################################################################

    localparam int XLEN       = 32;
    localparam int REG_IDX_W  = 5;
    localparam int CTRL_W     = 4;
    localparam int SHAMT_W    = 5;
    localparam int NUM_REGS   = 32;

    // queued micro-op: ctrl, rd, rs0, rs1, imm, use_imm
    localparam int UOP_W      = CTRL_W + 3 * REG_IDX_W + XLEN + 1;

    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_IDX_W-1:0]  reg_idx_t;
    typedef logic [CTRL_W-1:0]     alu_ctrl_t;
    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;

    localparam fifo_ptr_t FIFO_LAST = fifo_ptr_t'(FIFO_DEPTH - 1);
    localparam fifo_cnt_t FIFO_FULL = fifo_cnt_t'(FIFO_DEPTH);

    // ########################################################################
    // alu operation codes, 11..15 undefined
    // ########################################################################

    localparam alu_ctrl_t ALU_ADD  = 4'd0;
    localparam alu_ctrl_t ALU_SUB  = 4'd1;
    localparam alu_ctrl_t ALU_SLT  = 4'd2;
    localparam alu_ctrl_t ALU_SLTU = 4'd3;
    localparam alu_ctrl_t ALU_AND  = 4'd4;
    localparam alu_ctrl_t ALU_OR   = 4'd5;
    localparam alu_ctrl_t ALU_NOR  = 4'd6;
    localparam alu_ctrl_t ALU_XOR  = 4'd7;
    localparam alu_ctrl_t ALU_SLL  = 4'd8;
    localparam alu_ctrl_t ALU_SRL  = 4'd9;
    localparam alu_ctrl_t ALU_SRA  = 4'd10;

endpackage

`default_nettype wire

// ==== hdl/exu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module exu_top (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               uop_valid,
    output logic                    uop_ready,
    input  wire exu_pkg::alu_ctrl_t uop_ctrl,
    input  wire exu_pkg::reg_idx_t  uop_rd,
    input  wire exu_pkg::reg_idx_t  uop_rs0,
    input  wire exu_pkg::reg_idx_t  uop_rs1,
    input  wire exu_pkg::word_t     uop_imm,
    input  wire logic               uop_use_imm,
    output logic                    wb_valid,
    input  wire logic               wb_ready,
    output exu_pkg::reg_idx_t       wb_rd,
    output exu_pkg::word_t          wb_result
);

    // queue -> issue
    logic               q_valid;
    logic               q_ready;
    exu_pkg::alu_ctrl_t q_ctrl;
    exu_pkg::reg_idx_t  q_rd;
    exu_pkg::reg_idx_t  q_rs0;
    exu_pkg::reg_idx_t  q_rs1;
    exu_pkg::word_t     q_imm;
    logic               q_use_imm;
    // register file
    exu_pkg::reg_idx_t  rf_rs0_addr;
    exu_pkg::reg_idx_t  rf_rs1_addr;
    exu_pkg::word_t     rf_rs0_data;
    exu_pkg::word_t     rf_rs1_data;
    logic               rf_we;
    exu_pkg::reg_idx_t  rf_waddr;
    exu_pkg::word_t     rf_wdata;
    // issue -> execute
    logic               iss_valid;
    logic               iss_ready;
    exu_pkg::alu_ctrl_t iss_ctrl;
    exu_pkg::reg_idx_t  iss_rd;
    exu_pkg::word_t     iss_sr0;
    exu_pkg::word_t     iss_sr1;
    // execute -> writeback
    logic               ex_valid;
    logic               ex_ready;
    exu_pkg::reg_idx_t  ex_rd;
    exu_pkg::word_t     ex_result;

    uop_fifo i_uop_fifo (
        .clk (clk), .rst_n (rst_n),
        .in_valid (uop_valid), .in_ready (uop_ready),
        .in_ctrl (uop_ctrl), .in_rd (uop_rd), .in_rs0 (uop_rs0), .in_rs1 (uop_rs1),
        .in_imm (uop_imm), .in_use_imm (uop_use_imm),
        .out_valid (q_valid), .out_ready (q_ready),
        .out_ctrl (q_ctrl), .out_rd (q_rd), .out_rs0 (q_rs0), .out_rs1 (q_rs1),
        .out_imm (q_imm), .out_use_imm (q_use_imm)
    );

    issue_stage i_issue_stage (
        .clk (clk), .rst_n (rst_n),
        .in_valid (q_valid), .in_ready (q_ready),
        .in_ctrl (q_ctrl), .in_rd (q_rd), .in_rs0 (q_rs0), .in_rs1 (q_rs1),
        .in_imm (q_imm), .in_use_imm (q_use_imm),
        .rf_rs0_addr (rf_rs0_addr), .rf_rs1_addr (rf_rs1_addr),
        .rf_rs0_data (rf_rs0_data), .rf_rs1_data (rf_rs1_data),
        .rf_we (rf_we), .rf_waddr (rf_waddr),
        .out_valid (iss_valid), .out_ready (iss_ready),
        .out_ctrl (iss_ctrl), .out_rd (iss_rd), .out_sr0 (iss_sr0), .out_sr1 (iss_sr1)
    );

    reg_file i_reg_file (
        .clk (clk), .rst_n (rst_n),
        .rs0_addr (rf_rs0_addr), .rs1_addr (rf_rs1_addr),
        .rs0_data (rf_rs0_data), .rs1_data (rf_rs1_data),
        .we (rf_we), .waddr (rf_waddr), .wdata (rf_wdata)
    );

    exec_stage i_exec_stage (
        .clk (clk), .rst_n (rst_n),
        .in_valid (iss_valid), .in_ready (iss_ready),
        .in_ctrl (iss_ctrl), .in_rd (iss_rd), .in_sr0 (iss_sr0), .in_sr1 (iss_sr1),
        .out_valid (ex_valid), .out_ready (ex_ready),
        .out_rd (ex_rd), .out_result (ex_result)
    );

    writeback_stage i_writeback_stage (
        .clk (clk), .rst_n (rst_n),
        .in_valid (ex_valid), .in_ready (ex_ready),
        .in_rd (ex_rd), .in_result (ex_result),
        .wb_valid (wb_valid), .wb_ready (wb_ready),
        .wb_rd (wb_rd), .wb_result (wb_result),
        .rf_we (rf_we), .rf_waddr (rf_waddr), .rf_wdata (rf_wdata)
    );

endmodule

`default_nettype wire

// ==== hdl/issue_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module issue_stage (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               in_valid,
    output logic                    in_ready,
    input  wire exu_pkg::alu_ctrl_t in_ctrl,
    input  wire exu_pkg::reg_idx_t  in_rd,
    input  wire exu_pkg::reg_idx_t  in_rs0,
    input  wire exu_pkg::reg_idx_t  in_rs1,
    input  wire exu_pkg::word_t     in_imm,
    input  wire logic               in_use_imm,
    output exu_pkg::reg_idx_t       rf_rs0_addr,
    output exu_pkg::reg_idx_t       rf_rs1_addr,
    input  wire exu_pkg::word_t     rf_rs0_data,
    input  wire exu_pkg::word_t     rf_rs1_data,
    input  wire logic               rf_we,
    input  wire exu_pkg::reg_idx_t  rf_waddr,
    output logic                    out_valid,
    input  wire logic               out_ready,
    output exu_pkg::alu_ctrl_t      out_ctrl,
    output exu_pkg::reg_idx_t       out_rd,
    output exu_pkg::word_t          out_sr0,
    output exu_pkg::word_t          out_sr1
);

    logic [exu_pkg::NUM_REGS-1:0] pending;
    logic                         hazard;
    logic                         out_free;
    logic                         take;

    assign rf_rs0_addr = in_rs0;
    assign rf_rs1_addr = in_rs1;

    // ########################################################################
    // scoreboard
    // ########################################################################

    // bit 0 is never set, so r0 never stalls
    assign hazard   = pending[in_rs0] || pending[in_rs1] || pending[in_rd];
    assign out_free = !out_valid || out_ready;
    assign in_ready = out_free && !hazard;
    assign take     = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            // release on the writeback handshake
            if (rf_we) begin
                pending[rf_waddr] <= 1'b0;
            end
            // claim rd when latched here, so a younger op
            // can never read the register file before this write
            if (take && (in_rd != '0)) begin
                pending[in_rd] <= 1'b1;
            end
        end
    end

    // ########################################################################
    // output register toward execute
    // ########################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (out_free) begin
            out_valid <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_ctrl <= in_ctrl;
            out_rd   <= in_rd;
            out_sr0  <= rf_rs0_data;
            out_sr1  <= in_use_imm ? in_imm : rf_rs1_data;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire exu_pkg::reg_idx_t rs0_addr,
    input  wire exu_pkg::reg_idx_t rs1_addr,
    output exu_pkg::word_t         rs0_data,
    output exu_pkg::word_t         rs1_data,
    input  wire logic              we,
    input  wire exu_pkg::reg_idx_t waddr,
    input  wire exu_pkg::word_t    wdata
);

    exu_pkg::word_t regs [exu_pkg::NUM_REGS];

    // ########################################################################
    // write port, register 0 never written
    // ########################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < exu_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // ########################################################################
    // combinational read ports
    // ########################################################################

    assign rs0_data = (rs0_addr == '0) ? '0 : regs[rs0_addr];
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];

endmodule

`default_nettype wire

// ==== hdl/uop_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module uop_fifo (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               in_valid,
    output logic                    in_ready,
    input  wire exu_pkg::alu_ctrl_t in_ctrl,
    input  wire exu_pkg::reg_idx_t  in_rd,
    input  wire exu_pkg::reg_idx_t  in_rs0,
    input  wire exu_pkg::reg_idx_t  in_rs1,
    input  wire exu_pkg::word_t     in_imm,
    input  wire logic               in_use_imm,
    output logic                    out_valid,
    input  wire logic               out_ready,
    output exu_pkg::alu_ctrl_t      out_ctrl,
    output exu_pkg::reg_idx_t       out_rd,
    output exu_pkg::reg_idx_t       out_rs0,
    output exu_pkg::reg_idx_t       out_rs1,
    output exu_pkg::word_t          out_imm,
    output logic                    out_use_imm
);

    logic [exu_pkg::UOP_W-1:0] mem [exu_pkg::FIFO_DEPTH];
    logic [exu_pkg::UOP_W-1:0] head;
    exu_pkg::fifo_ptr_t        wr_ptr;
    exu_pkg::fifo_ptr_t        rd_ptr;
    exu_pkg::fifo_cnt_t        count;
    logic                      push;
    logic                      pop;

    assign in_ready = (count != exu_pkg::FIFO_FULL);
    assign push     = in_valid && in_ready;
    // refill head register when empty or being taken
    assign pop      = (count != '0) && (!out_valid || out_ready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == exu_pkg::FIFO_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == exu_pkg::FIFO_LAST) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
            if (pop) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {in_ctrl, in_rd, in_rs0, in_rs1, in_imm, in_use_imm};
        end
        if (pop) begin
            head <= mem[rd_ptr];
        end
    end

    assign {out_ctrl, out_rd, out_rs0, out_rs1, out_imm, out_use_imm} = head;

endmodule

`default_nettype wire

// ==== hdl/writeback_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module writeback_stage (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              in_valid,
    output logic                   in_ready,
    input  wire exu_pkg::reg_idx_t in_rd,
    input  wire exu_pkg::word_t    in_result,
    output logic                   wb_valid,
    input  wire logic              wb_ready,
    output exu_pkg::reg_idx_t      wb_rd,
    output exu_pkg::word_t         wb_result,
    output logic                   rf_we,
    output exu_pkg::reg_idx_t      rf_waddr,
    output exu_pkg::word_t         rf_wdata
);

    assign in_ready = !wb_valid || wb_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else if (in_ready) begin
            wb_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            wb_rd     <= in_rd;
            wb_result <= in_result;
        end
    end

    // commit on the output handshake, r0 results only go out
    assign rf_we    = wb_valid && wb_ready && (wb_rd != '0);
    assign rf_waddr = wb_rd;
    assign rf_wdata = wb_result;

endmodule

`default_nettype wire

// ==== sources.f ====
hdl/exu_pkg.sv
hdl/uop_fifo.sv
hdl/reg_file.sv
hdl/issue_stage.sv
hdl/alu.sv
hdl/exec_stage.sv
hdl/writeback_stage.sv
hdl/exu_top.sv
dv/exu_tb.sv
